//--- hdl/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// Data path and instruction word width
	localparam int DATA_W = 16;

	// Operation field, top four bits of every instruction
	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SHL,
		SHR,
		LDI,
		LD,
		LDR,
		ST,
		JMP,
		JR,
		BZ,
		BC,
		NOP
	} opcode_t;

	// Next program counter source
	typedef enum logic [1:0] {
		PC_INC,
		PC_IMM,
		PC_REG
	} pcSel_t;

	// Register write-back source
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_IMM
	} wbSel_t;

	// Register-register and register-immediate views of one word
	typedef union packed {
		struct packed {
			opcode_t opcode;
			logic [1:0] rd;
			logic [1:0] rs1;
			logic [1:0] rs2;
			logic [DATA_W-11:0] pad;
		} regForm;
		struct packed {
			opcode_t opcode;
			logic [1:0] rd;
			logic [1:0] rs1;
			logic [DATA_W-9:0] imm;
		} immForm;
	} instrWord_t;

endpackage

`default_nettype wire

//--- hdl/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter import cpuPkg::*; #(
	parameter int MEM_DEPTH = 128,
	localparam int ADDR_W = $clog2(MEM_DEPTH)
) (
	input wire logic clk,
	input wire logic rst,
	input wire pcSel_t pcSel,
	input wire logic [DATA_W-1:0] imm,
	input wire logic [DATA_W-1:0] regTarget,
	output logic [ADDR_W-1:0] pc
);

	logic [ADDR_W-1:0] nextPc;

	// Targets are truncated, so every jump wraps inside the memory
	always_comb begin
		case (pcSel)
			PC_IMM: nextPc = imm[ADDR_W-1:0];
			PC_REG: nextPc = regTarget[ADDR_W-1:0];
			default: nextPc = pc + 1'b1;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import cpuPkg::*; (
	input wire logic rst,
	input wire instrWord_t instr,
	input wire logic cFlag,
	input wire logic zFlag,
	output opcode_t aluOp,
	output logic [1:0] rdSel,
	output logic [1:0] rs1Sel,
	output logic [1:0] rs2Sel,
	output logic regWe,
	output wbSel_t wbSel,
	output logic memWe,
	output logic memAddrSel,
	output pcSel_t pcSel,
	output logic [DATA_W-1:0] imm
);

	opcode_t op;

	assign op = instr.immForm.opcode;
	assign aluOp = op;
	assign imm = DATA_W'(instr.immForm.imm);

	always_comb begin
		// Immediate form by default; ST reads rd on the second port
		rdSel = instr.immForm.rd;
		rs1Sel = instr.immForm.rs1;
		rs2Sel = instr.immForm.rd;
		regWe = 1'b0;
		wbSel = WB_ALU;
		memWe = 1'b0;
		memAddrSel = 1'b0;
		pcSel = PC_INC;

		case (op)
			ADD, SUB, AND, OR, XOR, SHL, SHR: begin
				rs2Sel = instr.regForm.rs2;
				regWe = 1'b1;
			end
			LDI: begin
				regWe = 1'b1;
				wbSel = WB_IMM;
			end
			LD: begin
				regWe = 1'b1;
				wbSel = WB_MEM;
			end
			LDR: begin
				regWe = 1'b1;
				wbSel = WB_MEM;
				// Address from rs1 instead of the immediate
				memAddrSel = 1'b1;
			end
			ST: begin
				memWe = 1'b1;
			end
			JMP: begin
				pcSel = PC_IMM;
			end
			JR: begin
				pcSel = PC_REG;
			end
			BZ: begin
				if (zFlag) begin
					pcSel = PC_IMM;
				end
			end
			BC: begin
				if (cFlag) begin
					pcSel = PC_IMM;
				end
			end
			default: begin
			end
		endcase

		// No commits while held in reset
		if (rst) begin
			regWe = 1'b0;
			memWe = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile import cpuPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic we,
	input wire logic [1:0] wrSel,
	input wire wbSel_t wbSel,
	input wire logic [DATA_W-1:0] aluResult,
	input wire logic [DATA_W-1:0] memData,
	input wire logic [DATA_W-1:0] imm,
	input wire logic [1:0] rs1Sel,
	input wire logic [1:0] rs2Sel,
	output logic [DATA_W-1:0] rdData1,
	output logic [DATA_W-1:0] rdData2,
	output logic [DATA_W-1:0] wrData
);

	logic [DATA_W-1:0] regs [4];

	// Write-back source
	always_comb begin
		case (wbSel)
			WB_MEM: wrData = memData;
			WB_IMM: wrData = imm;
			default: wrData = aluResult;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wrSel] <= wrData;
		end
	end

	assign rdData1 = regs[rs1Sel];
	assign rdData2 = regs[rs2Sel];

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpuPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire opcode_t op,
	input wire logic [DATA_W-1:0] in1,
	input wire logic [DATA_W-1:0] in2,
	output logic [DATA_W-1:0] result,
	output logic cFlag,
	output logic zFlag
);

	// One extra bit on top holds carry, borrow or the last bit shifted out
	logic [DATA_W:0] wide;
	logic [3:0] shamt;
	logic carry;

	assign shamt = in2[3:0];

	always_comb begin
		case (op)
			ADD: wide = {1'b0, in1} + {1'b0, in2};
			SUB: wide = {1'b0, in1} - {1'b0, in2};
			AND: wide = {1'b0, in1 & in2};
			OR: wide = {1'b0, in1 | in2};
			XOR: wide = {1'b0, in1 ^ in2};
			SHL: wide = {1'b0, in1} << shamt;
			SHR: wide = {1'b0, in1 >> shamt};
			default: wide = '0;
		endcase
	end

	assign result = wide[DATA_W-1:0];
	assign carry = wide[DATA_W];

	// Flags only follow the arithmetic and logic group
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (op inside {ADD, SUB, AND, OR, XOR, SHL, SHR}) begin
			cFlag <= carry;
			zFlag <= (result == '0);
		end
	end

endmodule

`default_nettype wire

//--- hdl/cpuMemory.sv
`timescale 1ns/1ps
`default_nettype none

module cpuMemory import cpuPkg::*; #(
	parameter int MEM_DEPTH = 128,
	localparam int ADDR_W = $clog2(MEM_DEPTH)
) (
	input wire logic clk,
	input wire logic progWe,
	input wire logic [ADDR_W-1:0] progAddr,
	input wire logic [DATA_W-1:0] progData,
	input wire logic [ADDR_W-1:0] pc,
	input wire logic dWe,
	input wire logic [ADDR_W-1:0] dAddr,
	input wire logic [DATA_W-1:0] dWrData,
	output logic [DATA_W-1:0] instr,
	output logic [DATA_W-1:0] dRdData
);

	logic [DATA_W-1:0] instrMem [MEM_DEPTH];
	logic [DATA_W-1:0] dataMem [MEM_DEPTH];

	// Loads of never-stored words read zero
	initial begin
		for (int i = 0; i < MEM_DEPTH; i++) begin
			dataMem[i] = '0;
		end
	end

	// Program load port, only path into instruction memory
	always @(posedge clk) begin
		if (progWe) begin
			instrMem[progAddr] <= progData;
		end
	end

	always @(posedge clk) begin
		if (dWe) begin
			dataMem[dAddr] <= dWrData;
		end
	end

	assign instr = instrMem[pc];
	assign dRdData = dataMem[dAddr];

endmodule

`default_nettype wire

//--- hdl/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu import cpuPkg::*; #(
	parameter int MEM_DEPTH = 128,
	localparam int ADDR_W = $clog2(MEM_DEPTH)
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic progWe,
	input wire logic [ADDR_W-1:0] progAddr,
	input wire logic [DATA_W-1:0] progData,
	output logic [ADDR_W-1:0] tracePc,
	output logic wbEn,
	output logic [1:0] wbReg,
	output logic [DATA_W-1:0] wbData,
	output logic stEn,
	output logic [ADDR_W-1:0] stAddr,
	output logic [DATA_W-1:0] stData
);

	logic [ADDR_W-1:0] pc;
	logic [DATA_W-1:0] instr;
	opcode_t aluOp;
	logic [1:0] rdSel;
	logic [1:0] rs1Sel;
	logic [1:0] rs2Sel;
	logic regWe;
	wbSel_t wbSel;
	logic memWe;
	logic memAddrSel;
	pcSel_t pcSel;
	logic [DATA_W-1:0] imm;
	logic [DATA_W-1:0] rdData1;
	logic [DATA_W-1:0] rdData2;
	logic [DATA_W-1:0] wrData;
	logic [DATA_W-1:0] aluResult;
	logic cFlag;
	logic zFlag;
	logic [ADDR_W-1:0] memAddr;
	logic [DATA_W-1:0] memData;

	// Data address, immediate for LD/ST or rs1 for LDR
	assign memAddr = memAddrSel ? rdData1[ADDR_W-1:0] : imm[ADDR_W-1:0];

	programCounter #(.MEM_DEPTH(MEM_DEPTH)) pcReg (
		.clk(clk), .rst(rst), .pcSel(pcSel), .imm(imm), .regTarget(rdData1), .pc(pc)
	);

	instrDecoder decode (
		.rst(rst), .instr(instr), .cFlag(cFlag), .zFlag(zFlag), .aluOp(aluOp),
		.rdSel(rdSel), .rs1Sel(rs1Sel), .rs2Sel(rs2Sel), .regWe(regWe), .wbSel(wbSel),
		.memWe(memWe), .memAddrSel(memAddrSel), .pcSel(pcSel), .imm(imm)
	);

	registerFile regFile (
		.clk(clk), .rst(rst), .we(regWe), .wrSel(rdSel), .wbSel(wbSel),
		.aluResult(aluResult), .memData(memData), .imm(imm), .rs1Sel(rs1Sel),
		.rs2Sel(rs2Sel), .rdData1(rdData1), .rdData2(rdData2), .wrData(wrData)
	);

	alu aluUnit (
		.clk(clk), .rst(rst), .op(aluOp), .in1(rdData1), .in2(rdData2),
		.result(aluResult), .cFlag(cFlag), .zFlag(zFlag)
	);

	cpuMemory #(.MEM_DEPTH(MEM_DEPTH)) mem (
		.clk(clk), .progWe(progWe), .progAddr(progAddr), .progData(progData), .pc(pc),
		.dWe(memWe), .dAddr(memAddr), .dWrData(rdData2), .instr(instr), .dRdData(memData)
	);

	// Trace of this cycle's commit
	assign tracePc = pc;
	assign wbEn = regWe;
	assign wbReg = rdSel;
	assign wbData = wrData;
	assign stEn = memWe;
	assign stAddr = memAddr;
	assign stData = rdData2;

endmodule

`default_nettype wire

//--- sim/cpuChecker.sv
`timescale 1ns/1ps
`default_nettype none

module cpuChecker import cpuPkg::*; #(
	parameter int MEM_DEPTH = 128,
	localparam int ADDR_W = $clog2(MEM_DEPTH)
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic progWe,
	input wire logic [ADDR_W-1:0] progAddr,
	input wire logic [DATA_W-1:0] progData,
	input wire logic [ADDR_W-1:0] tracePc,
	input wire logic wbEn,
	input wire logic [1:0] wbReg,
	input wire logic [DATA_W-1:0] wbData,
	input wire logic stEn,
	input wire logic [ADDR_W-1:0] stAddr,
	input wire logic [DATA_W-1:0] stData,
	output int errorCount,
	output int checkCount
);

	// Reference machine state
	logic [DATA_W-1:0] prog [MEM_DEPTH];
	logic [DATA_W-1:0] dmem [MEM_DEPTH];
	logic [DATA_W-1:0] regs [4];
	logic [ADDR_W-1:0] pc;
	logic cf;
	logic zf;
	int errors = 0;
	int checks = 0;

	assign errorCount = errors;
	assign checkCount = checks;

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s at pc %0d: expected %0h, actual %0h",
				name, pc, expected, actual);
		end
	endtask

	task automatic resetModel();
		pc = '0;
		cf = 1'b0;
		zf = 1'b0;
		for (int i = 0; i < 4; i++) begin
			regs[i] = '0;
		end
		// Data memory is only ever zero before the first store
		for (int i = 0; i < MEM_DEPTH; i++) begin
			dmem[i] = '0;
		end
	endtask

	// One instruction of the ISA checked against this cycle's trace
	task automatic step();
		logic [DATA_W-1:0] word;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] immVal;
		logic [DATA_W-1:0] wbVal;
		logic [1:0] rd;
		logic [ADDR_W-1:0] addr;
		logic [ADDR_W-1:0] nextPc;
		logic carry;
		logic expWe;
		logic expSt;
		int sh;
		opcode_t op;
		word = prog[pc];
		op = opcode_t'(word[15:12]);
		rd = word[11:10];
		a = regs[word[9:8]];
		b = regs[word[7:6]];
		sh = 32'(b[3:0]);
		immVal = {8'h00, word[7:0]};
		addr = immVal[ADDR_W-1:0];
		nextPc = pc + 1'b1;
		wbVal = '0;
		carry = 1'b0;
		expSt = (op == ST);
		expWe = op inside {ADD, SUB, AND, OR, XOR, SHL, SHR, LDI, LD, LDR};
		case (op)
			ADD: begin
				wbVal = a + b;
				// Sum wrapped past the top means a carry out
				carry = (wbVal < a);
			end
			SUB: begin
				wbVal = a - b;
				carry = (a < b);
			end
			AND: wbVal = a & b;
			OR: wbVal = a | b;
			XOR: wbVal = a ^ b;
			SHL: begin
				wbVal = a;
				// Carry holds the last bit pushed off the top
				for (int k = 0; k < sh; k++) begin
					carry = wbVal[DATA_W-1];
					wbVal = wbVal << 1;
				end
			end
			SHR: wbVal = a >> b[3:0];
			LDI: wbVal = immVal;
			LD: wbVal = dmem[addr];
			LDR: begin
				addr = a[ADDR_W-1:0];
				wbVal = dmem[addr];
			end
			JMP: nextPc = immVal[ADDR_W-1:0];
			JR: nextPc = a[ADDR_W-1:0];
			BZ: begin
				if (zf) begin
					nextPc = immVal[ADDR_W-1:0];
				end
			end
			BC: begin
				if (cf) begin
					nextPc = immVal[ADDR_W-1:0];
				end
			end
			default: begin
			end
		endcase

		compare("pc", 32'(pc), 32'(tracePc));
		compare($sformatf("%s wbEn", op.name()), 32'(expWe), 32'(wbEn));
		compare($sformatf("%s stEn", op.name()), 32'(expSt), 32'(stEn));
		if (expWe) begin
			compare($sformatf("%s wbReg", op.name()), 32'(rd), 32'(wbReg));
			compare($sformatf("%s wbData", op.name()), 32'(wbVal), 32'(wbData));
			regs[rd] = wbVal;
		end
		if (expSt) begin
			compare("ST stAddr", 32'(addr), 32'(stAddr));
			compare("ST stData", 32'(regs[rd]), 32'(stData));
			dmem[addr] = regs[rd];
		end
		if (op inside {ADD, SUB, AND, OR, XOR, SHL, SHR}) begin
			cf = carry;
			zf = (wbVal == '0);
		end
		pc = nextPc;
	endtask

	// Mid-cycle sampling where inputs and trace are settled
	always @(negedge clk) begin
		if (progWe) begin
			prog[progAddr] = progData;
		end
		if (rst) begin
			compare("reset wbEn", 32'd0, 32'(wbEn));
			compare("reset stEn", 32'd0, 32'(stEn));
			resetModel();
		end else begin
			step();
		end
	end

endmodule

`default_nettype wire

//--- sim/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb import cpuPkg::*; ();

	localparam int MEM_DEPTH = 128;
	localparam int ADDR_W = $clog2(MEM_DEPTH);
	localparam int RESET_CYCLES = 5;
	localparam int RUN_CYCLES = 400;
	localparam int CYCLE_LIMIT = MEM_DEPTH + RESET_CYCLES + RUN_CYCLES + 50;

	logic clk;
	logic rst;
	logic progWe;
	logic [ADDR_W-1:0] progAddr;
	logic [DATA_W-1:0] progData;
	logic [ADDR_W-1:0] tracePc;
	logic wbEn;
	logic [1:0] wbReg;
	logic [DATA_W-1:0] wbData;
	logic stEn;
	logic [ADDR_W-1:0] stAddr;
	logic [DATA_W-1:0] stData;
	int errorCount;
	int checkCount;
	int cycles;
	int seed;

	cpu #(.MEM_DEPTH(MEM_DEPTH)) uut (
		.clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
		.tracePc(tracePc), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
		.stEn(stEn), .stAddr(stAddr), .stData(stData)
	);

	cpuChecker #(.MEM_DEPTH(MEM_DEPTH)) cpuChecker (
		.clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
		.tracePc(tracePc), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
		.stEn(stEn), .stAddr(stAddr), .stData(stData),
		.errorCount(errorCount), .checkCount(checkCount)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// Weighted random instruction; every eighth word cycles through all opcodes
	task automatic makeInstr(input int addr, output logic [DATA_W-1:0] word);
		int roll;
		opcode_t op;
		logic [3:0] fields;
		logic [7:0] imm;
		roll = {$random(seed)} % 32;
		if (addr % 8 == 7) begin
			op = opcode_t'(addr / 8);
		end else if (roll < 14) begin
			op = opcode_t'(roll / 2);
		end else if (roll < 17) begin
			op = LDI;
		end else if (roll < 19) begin
			op = LD;
		end else if (roll < 21) begin
			op = LDR;
		end else if (roll < 24) begin
			op = ST;
		end else if (roll < 25) begin
			op = JMP;
		end else if (roll < 26) begin
			op = JR;
		end else if (roll < 28) begin
			op = BZ;
		end else if (roll < 30) begin
			op = BC;
		end else begin
			op = NOP;
		end
		fields = 4'($random(seed));
		imm = 8'($random(seed));
		// Few data addresses so loads meet earlier stores
		if (op inside {LD, ST}) begin
			imm = imm & 8'h0f;
		end
		// No jump straight onto itself
		if (op inside {JMP, BZ, BC} && imm[6:0] == addr[6:0]) begin
			imm = imm + 8'd1;
		end
		word = {op, fields, imm};
	endtask

	initial begin
		logic [DATA_W-1:0] word;
		seed = 59;
		cycles = 0;
		clk = 1'b0;
		rst = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;

		// Program load while the core sits in reset
		for (int i = 0; i < MEM_DEPTH; i++) begin
			@(posedge clk);
			makeInstr(i, word);
			progWe <= 1'b1;
			progAddr <= ADDR_W'(i);
			progData <= word;
		end
		@(posedge clk);
		progWe <= 1'b0;
		repeat (RESET_CYCLES - 1) @(posedge clk);
		rst <= 1'b0;

		repeat (RUN_CYCLES) @(posedge clk);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- cpu.f
hdl/cpuPkg.sv
hdl/programCounter.sv
hdl/instrDecoder.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/cpuMemory.sv
hdl/cpu.sv
sim/cpuChecker.sv
sim/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
TOP ?= cpuTb
FILELIST ?= cpu.f
BUILD_DIR ?= obj_dir
PASS_MSG := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
